// File: common/pf_pkg.sv
package pf_pkg;

    // Bus geometry
    localparam int ADDR_W      = 32;   // Wishbone and SDRAM address width
    localparam int WORD_STEP   = 4;    // Bytes per 32-bit word
    localparam int NUM_STREAMS = 3;    // FIR, QS and MM clients

    // Stream index
    // Each value is also the bit position in every per-stream vector
    typedef enum logic [1:0] {
        STREAM_MM  = 2'd0,
        STREAM_QS  = 2'd1,
        STREAM_FIR = 2'd2
    } stream_e;

    // Burst scheduler states
    typedef enum logic {
        SCHED_IDLE  = 1'b0,   // Waiting for an empty window
        SCHED_BURST = 1'b1    // Fetching one window for the selected stream
    } sched_state_e;

endpackage

// File: common/stream_if.sv
`timescale 1ns/1ps

// One prefetch stream as seen by the buffer, the hit stage and the scheduler
interface stream_if import pf_pkg::*; #(
    parameter int BURST_LEN = 8
);
    localparam int OCC_W = $clog2(BURST_LEN + 1);

    logic [ADDR_W-1:0] read_ptr;     // Next address served to the CPU
    logic [ADDR_W-1:0] fetch_addr;   // Next address fetched from SDRAM
    logic [OCC_W-1:0]  occ;          // Words held in the window
    logic              empty;        // No word left to serve
    logic              full;         // Window holds BURST_LEN words
    logic              initialized;  // Start address taken from the DMA
    logic              hit;          // Qualified Wishbone hit, one cycle
    logic              fill;         // Qualified SDRAM acknowledge, one cycle

    // Stream state owner
    modport buffer (
        output read_ptr, fetch_addr, occ, empty, full, initialized,
        input  hit, fill
    );

    // Wishbone hit stage
    modport hit_chk (
        input  read_ptr, empty,
        output hit
    );

    // Burst scheduler
    modport sched (
        input  fetch_addr, empty, full, initialized,
        output fill
    );

endinterface

// File: src/wb_hit_check.sv
`timescale 1ns/1ps

module wb_hit_check import pf_pkg::*; (
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    input  logic                   wbs_stb_i,
    input  logic                   wbs_cyc_i,
    input  logic [ADDR_W-1:0]      wbs_adr_i,
    input  logic                   run_i,      // Start flag, all windows were filled once
    stream_if.hit_chk              str_fir,
    stream_if.hit_chk              str_qs,
    stream_if.hit_chk              str_mm,
    output logic [NUM_STREAMS-1:0] hit_o,
    output logic                   wbs_ack_o
);

    logic bus_ok;     // Valid read cycle while running
    logic hit_fir;
    logic hit_qs;
    logic hit_mm;
    logic ack_q;

    assign bus_ok = run_i && wbs_stb_i && wbs_cyc_i;

    // A match only counts when the window still holds the word
    assign hit_fir = bus_ok && !str_fir.empty && (wbs_adr_i == str_fir.read_ptr);
    assign hit_qs  = bus_ok && !str_qs.empty  && (wbs_adr_i == str_qs.read_ptr);
    assign hit_mm  = bus_ok && !str_mm.empty  && (wbs_adr_i == str_mm.read_ptr);

    // Strobes back to the stream buffers
    assign str_fir.hit = hit_fir;
    assign str_qs.hit  = hit_qs;
    assign str_mm.hit  = hit_mm;

    // Same-cycle hit vector, bit order follows stream_e
    always_comb begin
        hit_o             = '0;
        hit_o[STREAM_FIR] = hit_fir;
        hit_o[STREAM_QS]  = hit_qs;
        hit_o[STREAM_MM]  = hit_mm;
    end

    // Acknowledge lands one cycle after the hit
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= hit_fir || hit_qs || hit_mm;   // Any stream served the read
        end
    end

    assign wbs_ack_o = ack_q;

endmodule

// File: prefetch/stream_buffer.sv
`timescale 1ns/1ps

module stream_buffer import pf_pkg::*; #(
    parameter  int BURST_LEN = 8,
    localparam int OCC_W     = $clog2(BURST_LEN + 1)
) (
    input  logic              wb_clk_i,
    input  logic              wb_rst_i,
    input  logic              init_ready_i,   // DMA start address valid
    input  logic [ADDR_W-1:0] init_addr_i,
    output logic [OCC_W-1:0]  occ_o,
    stream_if.buffer          str
);

    logic              init_q;    // Start address already taken
    logic [ADDR_W-1:0] fetch_q;   // Running SDRAM fetch address
    logic [ADDR_W-1:0] rptr_q;    // Next word the CPU will ask for
    logic [OCC_W-1:0]  occ_q;     // Words fetched but not yet served
    logic              load;

    // Only the first pulse after reset loads the stream
    assign load = init_ready_i && !init_q;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            init_q <= 1'b0;
        end else if (load) begin
            init_q <= 1'b1;
        end
    end

    // Fetch address walks ahead of the read pointer by the occupancy
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            fetch_q <= '0;
            rptr_q  <= '0;
        end else if (load) begin
            fetch_q <= init_addr_i;   // Both pointers start at the DMA address
            rptr_q  <= init_addr_i;
        end else begin
            if (str.fill) begin
                fetch_q <= fetch_q + ADDR_W'(WORD_STEP);   // One word landed
            end
            if (str.hit) begin
                rptr_q <= rptr_q + ADDR_W'(WORD_STEP);     // One word served
            end
        end
    end

    // Occupancy counter
    // Fill and hit together leave the count unchanged
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            occ_q <= '0;
        end else begin
            case ({str.fill, str.hit})
                2'b10:   occ_q <= occ_q + 1'b1;
                2'b01:   occ_q <= occ_q - 1'b1;
                default: occ_q <= occ_q;
            endcase
        end
    end

    // Levels straight from the count
    assign str.empty       = (occ_q == '0);
    assign str.full        = (occ_q == OCC_W'(BURST_LEN));
    assign str.initialized = init_q;
    assign str.read_ptr    = rptr_q;
    assign str.fetch_addr  = fetch_q;
    assign str.occ         = occ_q;

    assign occ_o = occ_q;

endmodule

// File: prefetch/burst_sched.sv
`timescale 1ns/1ps

module burst_sched import pf_pkg::*; #(
    parameter  int BURST_LEN = 8,
    localparam int CNT_W     = $clog2(BURST_LEN + 1)
) (
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    input  logic [NUM_STREAMS-1:0] f_ack_i,      // Per-stream SDRAM fetch acknowledge
    input  logic                   arb_busy_i,   // Holds off a new burst only
    stream_if.sched                str_fir,
    stream_if.sched                str_qs,
    stream_if.sched                str_mm,
    output logic [NUM_STREAMS-1:0] burst_req_o,
    output logic [ADDR_W-1:0]      addr2ram_o,
    output logic                   start_o,
    output logic [5:0]             state_reg_o
);

    sched_state_e           state_q;
    stream_e                sel_q;      // Stream owning the current burst
    stream_e                pick;       // Priority winner among empty streams
    logic [CNT_W-1:0]       cnt_q;      // Acknowledges still expected
    logic [NUM_STREAMS-1:0] sel_vec;    // One-hot of sel_q
    logic                   sel_ack;    // Acknowledge of the selected stream
    logic                   all_init;
    logic                   any_empty;
    logic                   all_full;
    logic                   start_q;

    assign all_init  = str_fir.initialized && str_qs.initialized && str_mm.initialized;
    assign any_empty = str_fir.empty || str_qs.empty || str_mm.empty;
    assign all_full  = str_fir.full && str_qs.full && str_mm.full;

    // Fixed priority FIR, then MM, then QS
    always_comb begin
        if (str_fir.empty) begin
            pick = STREAM_FIR;
        end else if (str_mm.empty) begin
            pick = STREAM_MM;
        end else begin
            pick = STREAM_QS;
        end
    end

    // Route address and acknowledge of the selected stream
    always_comb begin
        sel_vec    = '0;
        addr2ram_o = str_mm.fetch_addr;
        case (sel_q)
            STREAM_FIR: begin
                sel_vec[STREAM_FIR] = 1'b1;
                addr2ram_o          = str_fir.fetch_addr;
            end
            STREAM_QS: begin
                sel_vec[STREAM_QS] = 1'b1;
                addr2ram_o         = str_qs.fetch_addr;
            end
            default: begin
                sel_vec[STREAM_MM] = 1'b1;
            end
        endcase
    end

    assign burst_req_o = (state_q == SCHED_BURST) ? sel_vec : '0;
    assign sel_ack     = |(f_ack_i & burst_req_o);   // Unselected acks drop out here

    // Fill strobes, already qualified by the burst
    assign str_fir.fill = sel_ack && (sel_q == STREAM_FIR);
    assign str_qs.fill  = sel_ack && (sel_q == STREAM_QS);
    assign str_mm.fill  = sel_ack && (sel_q == STREAM_MM);

    // Scheduler FSM and burst counter
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q <= SCHED_IDLE;
            sel_q   <= STREAM_MM;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                SCHED_IDLE: begin
                    if (all_init && any_empty && !arb_busy_i) begin
                        state_q <= SCHED_BURST;
                        sel_q   <= pick;
                        cnt_q   <= CNT_W'(BURST_LEN);   // One full window
                    end
                end
                SCHED_BURST: begin
                    if (sel_ack) begin
                        cnt_q <= cnt_q - 1'b1;
                        if (cnt_q == CNT_W'(1)) begin
                            state_q <= SCHED_IDLE;      // Last word of the window
                        end
                    end
                end
            endcase
        end
    end

    // Sticky start once every window has been full
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            start_q <= 1'b0;
        end else if (all_full) begin
            start_q <= 1'b1;
        end
    end

    assign start_o = start_q;

    // FIR full/empty, QS full/empty, MM full/empty
    assign state_reg_o = {str_fir.full, str_fir.empty,
                          str_qs.full,  str_qs.empty,
                          str_mm.full,  str_mm.empty};

endmodule

// File: src/prefetch_ctrl.sv
`timescale 1ns/1ps

module prefetch_ctrl import pf_pkg::*; #(
    parameter  int BURST_LEN = 8,
    localparam int OCC_W     = $clog2(BURST_LEN + 1)
) (
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,

    // Wishbone slave, read hits only
    input  logic                   wbs_stb_i,
    input  logic                   wbs_cyc_i,
    input  logic [ADDR_W-1:0]      wbs_adr_i,
    output logic                   wbs_ack_o,
    output logic [NUM_STREAMS-1:0] hit_o,

    // DMA start addresses
    input  logic [ADDR_W-1:0]      init_addr_fir_i,
    input  logic [ADDR_W-1:0]      init_addr_qs_i,
    input  logic [ADDR_W-1:0]      init_addr_mm_i,
    input  logic [NUM_STREAMS-1:0] init_ready_i,

    // SDRAM fetch side
    input  logic [NUM_STREAMS-1:0] f_ack_i,
    input  logic                   arb_busy_i,
    output logic [NUM_STREAMS-1:0] burst_req_o,
    output logic [ADDR_W-1:0]      addr2ram_o,

    // Status
    output logic [OCC_W-1:0]       occ_fir_o,
    output logic [OCC_W-1:0]       occ_qs_o,
    output logic [OCC_W-1:0]       occ_mm_o,
    output logic [5:0]             state_reg_o,
    output logic                   start_o       // CPU may start, fed back as run
);

    // One bundle per stream
    stream_if #(.BURST_LEN(BURST_LEN)) if_fir ();
    stream_if #(.BURST_LEN(BURST_LEN)) if_qs  ();
    stream_if #(.BURST_LEN(BURST_LEN)) if_mm  ();

    stream_buffer #(.BURST_LEN(BURST_LEN)) u_fir (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .init_ready_i (init_ready_i[STREAM_FIR]),
        .init_addr_i  (init_addr_fir_i),
        .occ_o        (occ_fir_o),
        .str          (if_fir.buffer)
    );

    stream_buffer #(.BURST_LEN(BURST_LEN)) u_qs (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .init_ready_i (init_ready_i[STREAM_QS]),
        .init_addr_i  (init_addr_qs_i),
        .occ_o        (occ_qs_o),
        .str          (if_qs.buffer)
    );

    stream_buffer #(.BURST_LEN(BURST_LEN)) u_mm (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .init_ready_i (init_ready_i[STREAM_MM]),
        .init_addr_i  (init_addr_mm_i),
        .occ_o        (occ_mm_o),
        .str          (if_mm.buffer)
    );

    wb_hit_check u_hit (
        .wb_clk_i  (wb_clk_i),
        .wb_rst_i  (wb_rst_i),
        .wbs_stb_i (wbs_stb_i),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_adr_i (wbs_adr_i),
        .run_i     (start_o),        // Hits only after the initial fill
        .str_fir   (if_fir.hit_chk),
        .str_qs    (if_qs.hit_chk),
        .str_mm    (if_mm.hit_chk),
        .hit_o     (hit_o),
        .wbs_ack_o (wbs_ack_o)
    );

    burst_sched #(.BURST_LEN(BURST_LEN)) u_sched (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .f_ack_i     (f_ack_i),
        .arb_busy_i  (arb_busy_i),
        .str_fir     (if_fir.sched),
        .str_qs      (if_qs.sched),
        .str_mm      (if_mm.sched),
        .burst_req_o (burst_req_o),
        .addr2ram_o  (addr2ram_o),
        .start_o     (start_o),
        .state_reg_o (state_reg_o)
    );

endmodule

// File: tests/tb_driver.svh
`ifndef TB_DRIVER_SVH
`define TB_DRIVER_SVH

// Pseudo random source for ack gaps, busy cycles and miss addresses
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// Word address far away from every stream window
function automatic logic [ADDR_W-1:0] miss_addr();
    return 32'h4000_0000 + (lcg_next() & 32'h0000_fffc);
endfunction

// One Wishbone cycle, strobe optional
task automatic wb_read(input logic [ADDR_W-1:0] addr, input logic strobe);
    @(posedge wb_clk_i);
    wbs_cyc_i <= 1'b1;
    wbs_stb_i <= strobe;
    wbs_adr_i <= addr;
    @(posedge wb_clk_i);
    wbs_cyc_i <= 1'b0;
    wbs_stb_i <= 1'b0;
endtask

// SDRAM side of one burst
// Acks come with random gaps and random extra bits on other streams
task automatic serve_burst(input logic [NUM_STREAMS-1:0] expect_req);
    int          guard;
    logic [31:0] rnd;
    guard = 0;
    @(negedge wb_clk_i);
    while (burst_req_o == '0 && guard < TIMEOUT) begin
        @(negedge wb_clk_i);
        guard++;
    end
    if (burst_req_o == '0) begin
        timeout_errs++;
        $display("Timeout: no burst request came for stream mask %b", expect_req);
        return;
    end
    if (burst_req_o != expect_req) begin
        check_errs++;
        $display("FAILED at %0t: burst for %b, expected %b", $time, burst_req_o, expect_req);
    end
    guard = 0;
    while (burst_req_o != '0 && guard < TIMEOUT) begin
        @(posedge wb_clk_i);
        rnd = lcg_next();
        f_ack_i    <= rnd[18:16];
        arb_busy_i <= rnd[20] & rnd[21];   // Busy mid-burst must not stall it
        @(negedge wb_clk_i);
        guard++;
    end
    if (burst_req_o != '0) begin
        timeout_errs++;
        $display("Timeout: burst for stream mask %b never ended", expect_req);
    end
    @(posedge wb_clk_i);
    f_ack_i    <= '0;
    arb_busy_i <= 1'b0;
endtask

// Start flag after the three initial windows
task automatic wait_start();
    int guard;
    guard = 0;
    @(negedge wb_clk_i);
    while (!start_o && guard < TIMEOUT) begin
        @(negedge wb_clk_i);
        guard++;
    end
    if (!start_o) begin
        timeout_errs++;
        $display("Timeout: start_o never rose after the initial fill");
    end
endtask

`endif

// File: tests/tb_prefetch_ctrl.sv
`timescale 1ns/1ps

module tb_prefetch_ctrl import pf_pkg::*; ;

    localparam int BURST_LEN = 8;
    localparam int OCC_W     = $clog2(BURST_LEN + 1);
    localparam int TIMEOUT   = 400;   // Cycles per wait loop
    localparam logic [ADDR_W-1:0] FIR_BASE = 32'h1000_0000;
    localparam logic [ADDR_W-1:0] QS_BASE  = 32'h2000_0100;
    localparam logic [ADDR_W-1:0] MM_BASE  = 32'h3000_0200;

    logic                   wb_clk_i;
    logic                   wb_rst_i;
    logic                   wbs_stb_i;
    logic                   wbs_cyc_i;
    logic [ADDR_W-1:0]      wbs_adr_i;
    logic                   wbs_ack_o;
    logic [NUM_STREAMS-1:0] hit_o;
    logic [ADDR_W-1:0]      init_addr [NUM_STREAMS];   // Indexed by stream_e
    logic [NUM_STREAMS-1:0] init_ready_i;
    logic [NUM_STREAMS-1:0] f_ack_i;
    logic                   arb_busy_i;
    logic [NUM_STREAMS-1:0] burst_req_o;
    logic [ADDR_W-1:0]      addr2ram_o;
    logic [OCC_W-1:0]       occ_fir_o;
    logic [OCC_W-1:0]       occ_qs_o;
    logic [OCC_W-1:0]       occ_mm_o;
    logic [5:0]             state_reg_o;
    logic                   start_o;

    int unsigned lcg_state = 27;
    int          assert_errs = 0;
    int          check_errs = 0;
    int          timeout_errs = 0;

    // Reference model of the controller rules
    logic [NUM_STREAMS-1:0] m_init;
    logic [ADDR_W-1:0]      m_fetch [NUM_STREAMS];
    logic [ADDR_W-1:0]      m_rptr [NUM_STREAMS];
    int                     m_occ [NUM_STREAMS];
    logic                   m_busy;   // Burst in progress
    stream_e                m_sel;
    int                     m_cnt;    // Acks left in the burst
    logic                   m_start;
    logic                   m_ack;
    logic [NUM_STREAMS-1:0] m_hit;
    logic [NUM_STREAMS-1:0] m_fill;
    logic [5:0]             m_state;

    `include "tb_driver.svh"

    prefetch_ctrl #(.BURST_LEN(BURST_LEN)) dut0 (
        .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
        .wbs_stb_i(wbs_stb_i), .wbs_cyc_i(wbs_cyc_i), .wbs_adr_i(wbs_adr_i),
        .wbs_ack_o(wbs_ack_o), .hit_o(hit_o),
        .init_addr_fir_i(init_addr[STREAM_FIR]), .init_addr_qs_i(init_addr[STREAM_QS]),
        .init_addr_mm_i(init_addr[STREAM_MM]), .init_ready_i(init_ready_i),
        .f_ack_i(f_ack_i), .arb_busy_i(arb_busy_i),
        .burst_req_o(burst_req_o), .addr2ram_o(addr2ram_o),
        .occ_fir_o(occ_fir_o), .occ_qs_o(occ_qs_o), .occ_mm_o(occ_mm_o),
        .state_reg_o(state_reg_o), .start_o(start_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #50 wb_clk_i = ~wb_clk_i;
    end

    always_comb begin
        for (int s = 0; s < NUM_STREAMS; s++) begin
            m_hit[s]  = m_start && wbs_stb_i && wbs_cyc_i && (m_occ[s] != 0)
                        && (wbs_adr_i == m_rptr[s]);
            m_fill[s] = m_busy && (int'(m_sel) == s) && f_ack_i[s];   // Only the owner fills
        end
        m_state = {m_occ[STREAM_FIR] == BURST_LEN, m_occ[STREAM_FIR] == 0,
                   m_occ[STREAM_QS] == BURST_LEN,  m_occ[STREAM_QS] == 0,
                   m_occ[STREAM_MM] == BURST_LEN,  m_occ[STREAM_MM] == 0};
    end

    always @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            m_init  <= '0;
            m_busy  <= 1'b0;
            m_sel   <= STREAM_MM;
            m_cnt   <= 0;
            m_start <= 1'b0;
            m_ack   <= 1'b0;
            for (int s = 0; s < NUM_STREAMS; s++) begin
                m_fetch[s] <= '0;
                m_rptr[s]  <= '0;
                m_occ[s]   <= 0;
            end
        end else begin
            m_ack   <= |m_hit;
            m_start <= m_start || (m_state[5] && m_state[3] && m_state[1]);
            for (int s = 0; s < NUM_STREAMS; s++) begin
                if (init_ready_i[s] && !m_init[s]) begin
                    m_init[s]  <= 1'b1;
                    m_fetch[s] <= init_addr[s];
                    m_rptr[s]  <= init_addr[s];
                end else begin
                    m_fetch[s] <= m_fetch[s] + (m_fill[s] ? WORD_STEP : 0);
                    m_rptr[s]  <= m_rptr[s] + (m_hit[s] ? WORD_STEP : 0);
                end
                m_occ[s] <= m_occ[s] + int'(m_fill[s]) - int'(m_hit[s]);
            end
            if (!m_busy) begin
                if (&m_init && (m_state[4] || m_state[2] || m_state[0]) && !arb_busy_i) begin
                    m_busy <= 1'b1;
                    m_cnt  <= BURST_LEN;
                    if (m_occ[STREAM_FIR] == 0)     m_sel <= STREAM_FIR;
                    else if (m_occ[STREAM_MM] == 0) m_sel <= STREAM_MM;
                    else                            m_sel <= STREAM_QS;
                end
            end else if (|m_fill) begin
                m_cnt <= m_cnt - 1;
                if (m_cnt == 1) m_busy <= 1'b0;   // Last word of the window
            end
        end
    end

    // Failed assertion, counted and shown with its time
    function automatic void count_assert_fail(input string what);
        assert_errs++;
        $display("FAILED at %0t: %s", $time, what);
    endfunction

    a_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        burst_req_o == (m_busy ? (3'b001 << m_sel) : 3'b000))
        else count_assert_fail($sformatf("burst_req_o %b", burst_req_o));
    a_onehot: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) $onehot0(burst_req_o))
        else count_assert_fail("two burst requests");
    a_addr: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        !m_busy || addr2ram_o == m_fetch[m_sel])
        else count_assert_fail($sformatf("addr2ram_o %h", addr2ram_o));
    a_occ: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        int'(occ_fir_o) == m_occ[STREAM_FIR] && int'(occ_qs_o) == m_occ[STREAM_QS]
        && int'(occ_mm_o) == m_occ[STREAM_MM])
        else count_assert_fail("occupancy mismatch");
    a_state: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) state_reg_o == m_state)
        else count_assert_fail($sformatf("state_reg_o %b", state_reg_o));
    a_start: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) start_o == m_start)
        else count_assert_fail($sformatf("start_o %b", start_o));
    a_sticky: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) start_o |=> start_o)
        else count_assert_fail("start_o dropped");
    a_hit: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) hit_o == m_hit)
        else count_assert_fail($sformatf("hit_o %b", hit_o));
    a_ack: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i) wbs_ack_o == m_ack)
        else count_assert_fail($sformatf("wbs_ack_o %b", wbs_ack_o));

    initial begin
        wb_rst_i     = 1'b1;
        wbs_stb_i    = 1'b0;
        wbs_cyc_i    = 1'b0;
        wbs_adr_i    = '0;
        init_ready_i = '0;
        f_ack_i      = '0;
        arb_busy_i   = 1'b1;   // Idle scheduler held off until released
        init_addr[STREAM_FIR] = FIR_BASE;
        init_addr[STREAM_QS]  = QS_BASE;
        init_addr[STREAM_MM]  = MM_BASE;
        repeat (16) @(posedge wb_clk_i);
        wb_rst_i <= 1'b0;
        repeat (3) @(posedge wb_clk_i);
        init_ready_i <= 3'b111;
        @(posedge wb_clk_i);
        init_ready_i <= 3'b000;
        init_addr[STREAM_FIR] <= 32'h5000_0000;   // Second pulse must be ignored
        init_addr[STREAM_QS]  <= 32'h6000_0000;
        init_addr[STREAM_MM]  <= 32'h7000_0000;
        @(posedge wb_clk_i);
        init_ready_i <= 3'b111;
        @(posedge wb_clk_i);
        init_ready_i <= 3'b000;
        repeat (6) @(posedge wb_clk_i);
        arb_busy_i <= 1'b0;

        serve_burst(3'b001 << STREAM_FIR);
        wb_read(FIR_BASE, 1'b1);   // Before start, no ack
        serve_burst(3'b001 << STREAM_MM);
        serve_burst(3'b001 << STREAM_QS);
        wait_start();

        for (int i = 0; i < BURST_LEN; i++) begin
            wb_read(FIR_BASE + WORD_STEP * i, 1'b1);
            wb_read(miss_addr(), 1'b1);
            wb_read(QS_BASE, 1'b0);   // Cycle without strobe
        end
        wb_read(MM_BASE, 1'b1);
        wb_read(MM_BASE + WORD_STEP, 1'b1);
        wb_read(FIR_BASE + WORD_STEP * BURST_LEN, 1'b1);   // FIR drained
        serve_burst(3'b001 << STREAM_FIR);
        wb_read(FIR_BASE + WORD_STEP * BURST_LEN, 1'b1);
        wb_read(FIR_BASE + WORD_STEP * (BURST_LEN + 1), 1'b1);
        repeat (4) @(posedge wb_clk_i);

        $display("Errors: %0d assertion, %0d check, %0d timeout",
                 assert_errs, check_errs, timeout_errs);
        if (assert_errs + check_errs + timeout_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+tests
common/pf_pkg.sv
common/stream_if.sv
src/wb_hit_check.sv
prefetch/stream_buffer.sv
prefetch/burst_sched.sv
src/prefetch_ctrl.sv
tests/tb_prefetch_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the prefetch controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_prefetch_ctrl \
    -f verilog.f \
    -o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
